// ==== include/frontend_config.svh ====
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// Address and instruction widths
`define FE_ADDR_W        32
`define FE_INSN_W        32
`define FE_P_INSN_LEN    2

// Slots fetched per window and issued per cycle
`define FE_FETCH_W       2
`define FE_ISSUE_W       2

// Queue and BTB depth, log2
`define FE_P_IQ_DEPTH    3
`define FE_P_BTB_NUM     4

// Word address fetched after reset
`define FE_RESET_VECTOR  30'h0000_0040

`endif

// ==== logic/fetch_btb.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module fetch_btb
(
   input  logic                                       clk,
   input  logic                                       arst_n,
   input  logic                                       btb_rd_en,
   input  frontend_pkg::pc_t [`FE_FETCH_W-1:0]        btb_rd_pc,
   input  frontend_pkg::btb_wb_t                      bpu_wb,
   output frontend_pkg::btb_pred_t [`FE_FETCH_W-1:0]  btb_pred
);
   import frontend_pkg::*;

   localparam int NUM   = 1 << `FE_P_BTB_NUM;
   localparam int PC_W  = $bits(pc_t);
   localparam int TAG_W = PC_W - `FE_P_BTB_NUM;

   logic [NUM-1:0]             ent_valid;
   logic [TAG_W-1:0]           ent_tag [NUM];
   pc_t                        ent_tgt [NUM];
   logic [`FE_P_BTB_NUM-1:0]   wb_idx;
   logic [TAG_W-1:0]           wb_tag;
   logic                       wb_match;
   logic [`FE_FETCH_W-1:0]     rd_hit;
   pc_t [`FE_FETCH_W-1:0]      rd_tgt;

   assign wb_idx   = bpu_wb.pc[`FE_P_BTB_NUM-1:0];
   assign wb_tag   = bpu_wb.pc[PC_W-1:`FE_P_BTB_NUM];
   assign wb_match = ent_valid[wb_idx] & (ent_tag[wb_idx] == wb_tag);

   // Taken allocates, not-taken only kills a matching entry
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         ent_valid <= '0;
      else if (bpu_wb.valid)
      begin
         if (bpu_wb.taken)
            ent_valid[wb_idx] <= 1'b1;
         else if (wb_match)
            ent_valid[wb_idx] <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (bpu_wb.valid & bpu_wb.taken)
      begin
         ent_tag[wb_idx] <= wb_tag;
         ent_tgt[wb_idx] <= bpu_wb.tgt;
      end
   end

   // Both slots looked up in parallel
   always_comb
   begin
      for (int i = 0; i < `FE_FETCH_W; i++)
      begin
         rd_hit[i] = ent_valid[btb_rd_pc[i][`FE_P_BTB_NUM-1:0]] &
                     (ent_tag[btb_rd_pc[i][`FE_P_BTB_NUM-1:0]] ==
                      btb_rd_pc[i][PC_W-1:`FE_P_BTB_NUM]);
         rd_tgt[i] = ent_tgt[btb_rd_pc[i][`FE_P_BTB_NUM-1:0]];
      end
   end

   // Result lines up with the window in s1
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         btb_pred <= '0;
      else if (btb_rd_en)
      begin
         for (int i = 0; i < `FE_FETCH_W; i++)
         begin
            btb_pred[i].hit <= rd_hit[i];
            btb_pred[i].tgt <= rd_tgt[i];
         end
      end
   end

endmodule

// ==== logic/fetch_pc_gen.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module fetch_pc_gen
(
   input  logic                                          clk,
   input  logic                                          arst_n,
   input  logic                                          flush,
   input  frontend_pkg::pc_t                             flush_tgt,
   input  logic                                          iq_ready,
   input  frontend_pkg::window_t                         imem_rdata,
   input  frontend_pkg::btb_pred_t [`FE_FETCH_W-1:0]     btb_pred,
   output frontend_pkg::addr_t                           imem_addr,
   output logic                                          btb_rd_en,
   output frontend_pkg::pc_t [`FE_FETCH_W-1:0]           btb_rd_pc,
   output frontend_pkg::slot_cnt_t                       iq_push_cnt,
   output frontend_pkg::fetch_entry_t [`FE_FETCH_W-1:0]  iq_push
);
   import frontend_pkg::*;

   localparam int P_FW = $clog2(`FE_FETCH_W);

   logic                            p_ce;
   logic                            s1_ld;
   pc_t                             pc;
   pc_t                             pc_nxt;
   pc_t                             win_base;
   logic [`FE_FETCH_W-1:0]          s0_msk;
   pc_t [`FE_FETCH_W-1:0]           s0_pc;
   logic [`FE_FETCH_W-1:0]          s1_msk;
   pc_t [`FE_FETCH_W-1:0]           s1_pc;
   logic [`FE_FETCH_W-1:0]          s1_valid;
   logic [P_FW-1:0]                 s1_off;
   slot_cnt_t                       s1_cnt;
   logic                            pred_taken;
   pc_t                             pred_tgt;
   fetch_entry_t [`FE_FETCH_W-1:0]  s1_ent;

   assign p_ce  = iq_ready;
   // Flush must reach s1 even when the queue is full
   assign s1_ld = p_ce | flush;

   always_comb
   begin
      if (flush)
         pc_nxt = flush_tgt;
      else if (!p_ce)
         pc_nxt = pc;
      else if (pred_taken)
         pc_nxt = pred_tgt;
      else
         pc_nxt = pc + pc_t'(s1_cnt);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         pc <= `FE_RESET_VECTOR;
      else
         pc <= pc_nxt;
   end

   // Window-aligned request address
   assign win_base  = {pc_nxt[$bits(pc_t)-1:P_FW], {P_FW{1'b0}}};
   assign imem_addr = {win_base, {`FE_P_INSN_LEN{1'b0}}};

   always_comb
   begin
      for (int i = 0; i < `FE_FETCH_W; i++)
      begin
         s0_pc[i]  = win_base + pc_t'(i);
         // Slots before the target are dropped
         s0_msk[i] = (int'(pc_nxt[P_FW-1:0]) <= i);
      end
   end

   assign btb_rd_en = s1_ld;
   assign btb_rd_pc = s0_pc;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         s1_msk <= '0;
      else if (s1_ld)
         s1_msk <= s0_msk;
   end

   always_ff @(posedge clk)
   begin
      if (s1_ld)
         s1_pc <= s0_pc;
   end

   // Valid mask ends after the first predicted-taken slot
   always_comb
   begin
      pred_taken = 1'b0;
      pred_tgt   = btb_pred[0].tgt;
      s1_cnt     = '0;
      for (int i = 0; i < `FE_FETCH_W; i++)
      begin
         s1_valid[i] = s1_msk[i] & ~pred_taken;
         if (s1_valid[i])
            s1_cnt = s1_cnt + slot_cnt_t'(1);
         if (s1_valid[i] & btb_pred[i].hit)
         begin
            pred_taken = 1'b1;
            pred_tgt   = btb_pred[i].tgt;
         end
      end
   end

   always_comb
   begin
      for (int i = 0; i < `FE_FETCH_W; i++)
      begin
         s1_ent[i].pc         = s1_pc[i];
         s1_ent[i].insn       = imem_rdata[i*`FE_INSN_W +: `FE_INSN_W];
         s1_ent[i].pred_taken = s1_valid[i] & btb_pred[i].hit;
      end
   end

   // Valid slots are contiguous from the PC slot on
   assign s1_off = pc[P_FW-1:0];

   always_comb
   begin
      for (int j = 0; j < `FE_FETCH_W; j++)
      begin
         if (j + int'(s1_off) < `FE_FETCH_W)
            iq_push[j] = s1_ent[j + int'(s1_off)];
         else
            iq_push[j] = '0;
      end
   end

   assign iq_push_cnt = (p_ce & ~flush) ? s1_cnt : '0;

endmodule

// ==== logic/fetch_queue.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module fetch_queue
(
   input  logic                                          clk,
   input  logic                                          arst_n,
   input  logic                                          flush,
   input  frontend_pkg::slot_cnt_t                       iq_push_cnt,
   input  frontend_pkg::fetch_entry_t [`FE_FETCH_W-1:0]  iq_push,
   input  frontend_pkg::slot_cnt_t                       id_pop_cnt,
   output logic                                          iq_ready,
   output logic [`FE_ISSUE_W-1:0]                        id_valid,
   output frontend_pkg::fetch_entry_t [`FE_ISSUE_W-1:0]  id_slot
);
   import frontend_pkg::*;

   localparam int DEPTH = 1 << `FE_P_IQ_DEPTH;
   localparam int PTR_W = `FE_P_IQ_DEPTH;
   localparam int OCC_W = `FE_P_IQ_DEPTH + 1;

   logic [PTR_W-1:0]  rptr;
   logic [PTR_W-1:0]  wptr;
   logic [OCC_W-1:0]  occ;
   fetch_entry_t      mem [DEPTH];

   // Entry storage, up to two writes per cycle
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `FE_FETCH_W; i++)
      begin
         if (i < int'(iq_push_cnt))
            mem[wptr + PTR_W'(i)] <= iq_push[i];
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rptr <= '0;
         wptr <= '0;
         occ  <= '0;
      end
      else if (flush)
      begin
         rptr <= '0;
         wptr <= '0;
         occ  <= '0;
      end
      else
      begin
         wptr <= wptr + PTR_W'(iq_push_cnt);
         rptr <= rptr + PTR_W'(id_pop_cnt);
         occ  <= occ + OCC_W'(iq_push_cnt) - OCC_W'(id_pop_cnt);
      end
   end

   // Room for a full window
   assign iq_ready = (occ <= OCC_W'(DEPTH - `FE_FETCH_W));

   // Oldest entry always in slot 0
   always_comb
   begin
      for (int i = 0; i < `FE_ISSUE_W; i++)
      begin
         id_valid[i] = (occ > OCC_W'(i));
         id_slot[i]  = mem[rptr + PTR_W'(i)];
      end
   end

endmodule

// ==== logic/frontend.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module frontend
(
   input  logic                                          clk,
   input  logic                                          arst_n,
   input  logic                                          flush,
   input  frontend_pkg::pc_t                             flush_tgt,
   input  frontend_pkg::btb_wb_t                         bpu_wb,
   output frontend_pkg::addr_t                           imem_addr,
   input  frontend_pkg::window_t                         imem_rdata,
   output logic [`FE_ISSUE_W-1:0]                        id_valid,
   output frontend_pkg::fetch_entry_t [`FE_ISSUE_W-1:0]  id_slot,
   input  frontend_pkg::slot_cnt_t                       id_pop_cnt
);
   import frontend_pkg::*;

   logic                            btb_rd_en;
   pc_t [`FE_FETCH_W-1:0]           btb_rd_pc;
   btb_pred_t [`FE_FETCH_W-1:0]     btb_pred;
   slot_cnt_t                       iq_push_cnt;
   fetch_entry_t [`FE_FETCH_W-1:0]  iq_push;
   logic                            iq_ready;

   fetch_btb u_btb
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .btb_rd_en   (btb_rd_en),
      .btb_rd_pc   (btb_rd_pc),
      .bpu_wb      (bpu_wb),
      .btb_pred    (btb_pred)
   );

   fetch_pc_gen u_pc_gen
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .flush       (flush),
      .flush_tgt   (flush_tgt),
      .iq_ready    (iq_ready),
      .imem_rdata  (imem_rdata),
      .btb_pred    (btb_pred),
      .imem_addr   (imem_addr),
      .btb_rd_en   (btb_rd_en),
      .btb_rd_pc   (btb_rd_pc),
      .iq_push_cnt (iq_push_cnt),
      .iq_push     (iq_push)
   );

   fetch_queue u_queue
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .flush       (flush),
      .iq_push_cnt (iq_push_cnt),
      .iq_push     (iq_push),
      .id_pop_cnt  (id_pop_cnt),
      .iq_ready    (iq_ready),
      .id_valid    (id_valid),
      .id_slot     (id_slot)
   );

endmodule

// ==== logic/frontend_pkg.sv ====
`include "frontend_config.svh"

package frontend_pkg;

   typedef logic [`FE_ADDR_W-1:0] addr_t;
   // Word address, byte address without the two low zero bits
   typedef logic [`FE_ADDR_W-`FE_P_INSN_LEN-1:0] pc_t;
   typedef logic [`FE_INSN_W-1:0] insn_t;
   // One aligned fetch window, slot 0 in the low word
   typedef logic [`FE_INSN_W*`FE_FETCH_W-1:0] window_t;
   typedef logic [$clog2(`FE_FETCH_W+1)-1:0] slot_cnt_t;

   typedef struct packed {
      logic hit;
      pc_t  tgt;
   } btb_pred_t;

   // Branch resolution from writeback
   typedef struct packed {
      logic valid;
      logic taken;
      pc_t  pc;
      pc_t  tgt;
   } btb_wb_t;

   typedef struct packed {
      pc_t   pc;
      insn_t insn;
      logic  pred_taken;
   } fetch_entry_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the fetch frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module frontend_tb -Mdir "$BUILD"
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

"./$BUILD/Vfrontend_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
   echo "Failure reported in $LOG"
   exit 1
fi
exit 0

// ==== sim.f ====
+incdir+include
logic/frontend_pkg.sv
logic/fetch_btb.sv
logic/fetch_pc_gen.sv
logic/fetch_queue.sv
logic/frontend.sv
testbench/frontend_props.sv
testbench/frontend_tb.sv

// ==== testbench/frontend_props.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module frontend_props
(
   input logic                           clk,
   input logic                           arst_n,
   input logic [`FE_P_IQ_DEPTH:0]        occ,
   input logic [`FE_ISSUE_W-1:0]         id_valid,
   input frontend_pkg::slot_cnt_t        id_pop_cnt
);
   import frontend_pkg::*;

   localparam logic [`FE_P_IQ_DEPTH:0] DEPTH = 1 << `FE_P_IQ_DEPTH;

   logic [`FE_ISSUE_W-1:0] valid_inc;

   assign valid_inc = id_valid + 1'b1;

   occ_bound: assert property (@(posedge clk) disable iff (!arst_n) occ <= DEPTH)
      else $error("queue occupancy %0d above depth", occ);

   pop_bound: assert property (@(posedge clk) disable iff (!arst_n)
                               int'(id_pop_cnt) <= $countones(id_valid))
      else $error("pop count %0d above valid entries %b", id_pop_cnt, id_valid);

   // Valid bits fill from slot 0 upward
   valid_thermo: assert property (@(posedge clk) disable iff (!arst_n)
                                  (id_valid & valid_inc) == '0)
      else $error("id_valid %b not thermometer coded", id_valid);

endmodule

bind fetch_queue frontend_props u_props
(
   .clk        (clk),
   .arst_n     (arst_n),
   .occ        (occ),
   .id_valid   (id_valid),
   .id_pop_cnt (id_pop_cnt)
);

// ==== testbench/frontend_tb.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module frontend_tb;
   import frontend_pkg::*;

   localparam int  CLK_HALF   = 4;
   localparam int  WAIT_LIMIT = 200;
   localparam int  WATCHDOG   = 5000;
   localparam pc_t ODD_TGT    = 30'h0000_0123;
   localparam pc_t BR_PC      = 30'h0000_0200;
   localparam pc_t BR_TGT     = 30'h0000_0300;
   localparam pc_t REFILL_TGT = 30'h0000_0281;

   logic                            clk;
   logic                            arst_n;
   logic                            flush;
   pc_t                             flush_tgt;
   btb_wb_t                         bpu_wb;
   addr_t                           imem_addr;
   window_t                         imem_rdata;
   logic [`FE_ISSUE_W-1:0]          id_valid;
   fetch_entry_t [`FE_ISSUE_W-1:0]  id_slot;
   slot_cnt_t                       id_pop_cnt;

   addr_t   mem_addr_q = '0;
   pc_t     exp_pc;
   // Reference branch table, full PC as key
   pc_t     btb_model [pc_t];
   integer  seed;
   int      issued;
   int      checks;
   int      errors;
   int      tests_run;
   int      tests_failed;

   frontend u_dut
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .flush_tgt  (flush_tgt),
      .bpu_wb     (bpu_wb),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .id_valid   (id_valid),
      .id_slot    (id_slot),
      .id_pop_cnt (id_pop_cnt)
   );

   initial
   begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Instruction memory, data one cycle after the address
   always @(posedge clk)
      mem_addr_q <= imem_addr;

   // Each word holds the inverse of its own word address
   always_comb
   begin
      for (int i = 0; i < `FE_FETCH_W; i++)
         imem_rdata[i*`FE_INSN_W +: `FE_INSN_W] =
            ~insn_t'(mem_addr_q[`FE_ADDR_W-1:`FE_P_INSN_LEN] + pc_t'(i));
   end

   task check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got == exp)
      else
      begin
         $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Entries that leave the queue at the coming edge
   task check_pops;
      logic  hit;
      insn_t exp_insn;
      for (int i = 0; i < `FE_ISSUE_W; i++)
      begin
         if (i < int'(id_pop_cnt))
         begin
            hit      = (btb_model.exists(exp_pc) != 0);
            exp_insn = ~insn_t'(exp_pc);
            check_eq($sformatf("id_valid[%0d]", i), id_valid[i], 1);
            check_eq($sformatf("id_slot[%0d].pc", i), id_slot[i].pc, exp_pc);
            check_eq($sformatf("id_slot[%0d].insn", i), id_slot[i].insn, exp_insn);
            check_eq($sformatf("id_slot[%0d].pred_taken", i), id_slot[i].pred_taken, hit);
            // Next PC by the branch rule
            if (hit)
               exp_pc = btb_model[exp_pc];
            else
               exp_pc = exp_pc + pc_t'(1);
            issued++;
         end
      end
   endtask

   // Pop count chosen from what is surely still valid after the edge
   task tick(input int want);
      int avail;
      int n;
      @(negedge clk);
      check_pops();
      avail = $countones(id_valid) - int'(id_pop_cnt);
      n     = (want < avail) ? want : avail;
      if (n < 0)
         n = 0;
      @(posedge clk);
      id_pop_cnt <= slot_cnt_t'(n);
   endtask

   task do_flush(input pc_t tgt);
      @(negedge clk);
      check_pops();
      @(posedge clk);
      flush      <= 1'b1;
      flush_tgt  <= tgt;
      id_pop_cnt <= '0;
      @(posedge clk);
      flush      <= 1'b0;
      exp_pc = tgt;
   endtask

   task btb_write(input pc_t pc, input pc_t tgt, input logic taken);
      btb_wb_t wb;
      tick(0);
      wb.valid = 1'b1;
      wb.taken = taken;
      wb.pc    = pc;
      wb.tgt   = tgt;
      bpu_wb <= wb;
      @(posedge clk);
      bpu_wb <= '0;
      if (taken)
         btb_model[pc] = tgt;
      else
         btb_model.delete(pc);
   endtask

   // Called on the edge where the redirect is taken into s1
   task check_fill_latency;
      @(negedge clk);
      check_eq("id_valid", id_valid, 0);
      @(negedge clk);
      check_eq("id_valid[0]", id_valid[0], 1);
   endtask

   task run_until(input int count, input bit random_pops);
      int target;
      int cyc;
      int want;
      target = issued + count;
      cyc    = 0;
      while (issued < target && cyc < WAIT_LIMIT)
      begin
         if (random_pops)
            want = {$random(seed)} % 3;
         else
            want = `FE_ISSUE_W;
         tick(want);
         cyc++;
      end
      if (issued < target)
      begin
         $display("Timeout: only %0d of %0d instructions issued within %0d cycles",
                  count - (target - issued), count, WAIT_LIMIT);
         errors++;
      end
   endtask

   task finish_test(input string name, input int err0);
      tests_run++;
      if (errors == err0)
         $display("Test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("Test %s: %0d errors", name, errors - err0);
      end
   endtask

   task test_reset_stream;
      int err0;
      err0 = errors;
      // First edge out of reset loads s1
      @(posedge clk);
      check_fill_latency();
      run_until(12, 1'b0);
      finish_test("reset stream", err0);
   endtask

   task test_odd_flush;
      int err0;
      err0 = errors;
      do_flush(ODD_TGT);
      check_fill_latency();
      run_until(10, 1'b0);
      finish_test("odd flush target", err0);
   endtask

   task test_back_pressure;
      int err0;
      err0 = errors;
      repeat (20)
         tick(0);
      @(negedge clk);
      check_eq("id_valid", id_valid, {`FE_ISSUE_W{1'b1}});
      run_until(40, 1'b1);
      finish_test("back-pressure", err0);
   endtask

   task test_taken_branch;
      int err0;
      err0 = errors;
      btb_write(BR_PC, BR_TGT, 1'b1);
      do_flush(BR_PC - pc_t'(2));
      run_until(8, 1'b0);
      finish_test("taken prediction", err0);
   endtask

   task test_not_taken;
      int err0;
      err0 = errors;
      btb_write(BR_PC, BR_TGT, 1'b0);
      do_flush(BR_PC - pc_t'(2));
      run_until(8, 1'b0);
      finish_test("not-taken training", err0);
   endtask

   task test_flush_discard;
      int err0;
      err0 = errors;
      repeat (20)
         tick(0);
      do_flush(REFILL_TGT);
      check_fill_latency();
      run_until(10, 1'b1);
      finish_test("flush discards queue", err0);
   endtask

   initial
   begin
      arst_n       = 1'b0;
      flush        = 1'b0;
      flush_tgt    = '0;
      bpu_wb       = '0;
      id_pop_cnt   = '0;
      seed         = 32'he944_d8ee;
      exp_pc       = `FE_RESET_VECTOR;
      issued       = 0;
      checks       = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (2)
         @(posedge clk);
      arst_n <= 1'b1;
      test_reset_stream();
      test_odd_flush();
      test_back_pressure();
      test_taken_branch();
      test_not_taken();
      test_flush_discard();
      // Last pop count still pending
      tick(0);
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG)
         @(posedge clk);
      $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule
